/* lsu_pkg.sv */
package lsu_pkg;

    localparam int tag_w       = 4;
    localparam int slb_entries = 16;   // tag 0 reserved for "no dependency"
    localparam int xlen        = 32;
    localparam int ram_words   = 256;
    localparam int ram_aw      = $clog2(ram_words);

    typedef enum logic [2:0] {
        op_lb,
        op_lh,
        op_lw,
        op_lbu,
        op_lhu,
        op_sb,
        op_sh,
        op_sw
    } mem_op_e;

    typedef enum logic [1:0] {
        size_byte,
        size_half,
        size_word
    } acc_size_e;

    typedef struct packed {
        logic             en;
        mem_op_e          op;
        logic [tag_w-1:0] tag;        // destination tag, doubles as entry index
        logic [xlen-1:0]  imm;
        logic [tag_w-1:0] rs1_tag;
        logic [xlen-1:0]  rs1_data;
        logic [tag_w-1:0] rs2_tag;
        logic [xlen-1:0]  rs2_data;
    } dispatch_t;

    typedef struct packed {
        logic             en;
        logic [tag_w-1:0] tag;
        logic [xlen-1:0]  data;
    } cdb_t;

    typedef struct packed {
        logic             en;
        logic             is_store;
        logic             signed_ld;
        acc_size_e        size;
        logic [tag_w-1:0] tag;
        logic [xlen-1:0]  addr;
        logic [xlen-1:0]  wdata;
    } mem_req_t;

    typedef struct packed {
        logic             en;
        logic [tag_w-1:0] tag;
        logic [xlen-1:0]  data;
    } mem_rsp_t;

endpackage

/* data_ram.sv */
`timescale 1ns/1ps

module data_ram import lsu_pkg::*; (
    input  logic              clk,
    input  logic [ram_aw-1:0] addr,
    input  logic [3:0]        be,
    input  logic [xlen-1:0]   wdata,
    input  logic              we,
    output logic [xlen-1:0]   rdata
);

    logic [xlen-1:0] mem [ram_words];

    // memory starts out cleared
    initial begin
        for (int i = 0; i < ram_words; i++)
            mem[i] = '0;
    end

    always @(posedge clk) begin
        if (we) begin
            for (int b = 0; b < 4; b++) begin
                if (be[b])
                    mem[addr][8*b +: 8] <= wdata[8*b +: 8];
            end
        end
    end

    // read returns the old word on a same-cycle write
    always_ff @(posedge clk) begin
        rdata <= mem[addr];
    end

endmodule

/* lsu_mem_ctrl.sv */
`timescale 1ns/1ps

module lsu_mem_ctrl import lsu_pkg::*; (
    input  logic              clk,
    input  logic              rst,
    input  mem_req_t          mem_req,
    output logic              mem_busy,
    output mem_rsp_t          mem_rsp,
    output logic [ram_aw-1:0] ram_addr,
    output logic [3:0]        ram_be,
    output logic [xlen-1:0]   ram_wdata,
    output logic              ram_we,
    input  logic [xlen-1:0]   ram_rdata
);

    typedef struct packed {
        logic              is_store;
        logic              signed_ld;
        acc_size_e         size;
        logic [tag_w-1:0]  tag;
        logic [1:0]        off;    // byte offset, already aligned to size
        logic [ram_aw-1:0] word;
        logic [3:0]        be;
        logic [xlen-1:0]   wdata;
    } req_stage_t;

    typedef struct packed {
        logic             signed_ld;
        acc_size_e        size;
        logic [tag_w-1:0] tag;
        logic [1:0]       off;
    } data_stage_t;

    logic            s1_valid;
    req_stage_t      s1;
    logic            s2_valid;
    data_stage_t     s2;
    logic            accept;
    logic [1:0]      req_off;
    logic [3:0]      req_mask;
    logic [xlen-1:0] lane;

    // store data copied into every lane it may land in
    function automatic logic [xlen-1:0] lane_data(acc_size_e size, logic [xlen-1:0] d);
        case (size)
            size_byte: return {4{d[7:0]}};
            size_half: return {2{d[15:0]}};
            default:   return d;
        endcase
    endfunction

    assign mem_busy = s1_valid | s2_valid;
    assign accept   = mem_req.en && !mem_busy;

    // low address bits below the access size are dropped
    always_comb begin
        case (mem_req.size)
            size_byte: begin
                req_off  = mem_req.addr[1:0];
                req_mask = 4'b0001;
            end
            size_half: begin
                req_off  = {mem_req.addr[1], 1'b0};
                req_mask = 4'b0011;
            end
            default: begin
                req_off  = 2'b00;
                req_mask = 4'b1111;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst)
            s1_valid <= 1'b0;
        else
            s1_valid <= accept;
        if (accept) begin
            s1.is_store  <= mem_req.is_store;
            s1.signed_ld <= mem_req.signed_ld;
            s1.size      <= mem_req.size;
            s1.tag       <= mem_req.tag;
            s1.off       <= req_off;
            s1.word      <= mem_req.addr[ram_aw+1:2];   // wraps at ram size
            s1.be        <= req_mask << req_off;
            s1.wdata     <= lane_data(mem_req.size, mem_req.wdata);
        end
    end

    assign ram_addr  = s1.word;
    assign ram_be    = s1.be;
    assign ram_wdata = s1.wdata;
    assign ram_we    = s1_valid && s1.is_store;

    // loads only, read word arrives with this stage
    always_ff @(posedge clk) begin
        if (rst)
            s2_valid <= 1'b0;
        else
            s2_valid <= s1_valid && !s1.is_store;
        if (s1_valid) begin
            s2.signed_ld <= s1.signed_ld;
            s2.size      <= s1.size;
            s2.tag       <= s1.tag;
            s2.off       <= s1.off;
        end
    end

    assign lane = ram_rdata >> {s2.off, 3'b000};

    always_comb begin
        mem_rsp.en  = s2_valid;
        mem_rsp.tag = s2.tag;
        case (s2.size)
            size_byte: mem_rsp.data = {{(xlen-8){s2.signed_ld & lane[7]}}, lane[7:0]};
            size_half: mem_rsp.data = {{(xlen-16){s2.signed_ld & lane[15]}}, lane[15:0]};
            default:   mem_rsp.data = lane;
        endcase
    end

endmodule

/* slb.sv */
`timescale 1ns/1ps

module slb import lsu_pkg::*; (
    input  logic             clk,
    input  logic             rst,
    input  logic             clr,
    input  dispatch_t        dispatch,
    input  cdb_t             ex_cdb,
    input  cdb_t             self_cdb,
    input  logic             commit_en,
    input  logic [tag_w-1:0] commit_tag,
    input  logic             mem_busy,
    input  mem_rsp_t         mem_rsp,
    output mem_req_t         mem_req,
    output cdb_t             lsu_cdb,
    output logic             full
);

    typedef struct packed {
        logic             valid;
        logic [tag_w-1:0] tag;
        logic [xlen-1:0]  data;
    } operand_t;

    logic [slb_entries-1:1] occupied;
    logic [slb_entries-1:1] committed;   // stores released by the rob
    logic [slb_entries-1:1] issued;      // loads sitting in the controller
    mem_op_e                op_q  [1:slb_entries-1];
    logic [xlen-1:0]        imm_q [1:slb_entries-1];
    operand_t               rs1_q [1:slb_entries-1];
    operand_t               rs2_q [1:slb_entries-1];

    logic             st_hit;
    logic             ld_hit;
    logic [tag_w-1:0] st_idx;
    logic [tag_w-1:0] ld_idx;
    logic             sel_hit;
    logic [tag_w-1:0] sel_idx;
    logic             issue;
    logic             rsp_live;
    logic             dp_we;

    function automatic logic is_store(mem_op_e op);
        return op inside {op_sb, op_sh, op_sw};
    endfunction

    function automatic acc_size_e op_size(mem_op_e op);
        case (op)
            op_lb, op_lbu, op_sb: return size_byte;
            op_lh, op_lhu, op_sh: return size_half;
            default:              return size_word;
        endcase
    endfunction

    // fill a waiting operand from whichever bus carries its tag
    function automatic operand_t snoop(operand_t o, cdb_t ex, cdb_t self);
        operand_t r;
        r = o;
        if (!o.valid && ex.en && ex.tag == o.tag) begin
            r.valid = 1'b1;
            r.data  = ex.data;
        end else if (!o.valid && self.en && self.tag == o.tag) begin
            r.valid = 1'b1;
            r.data  = self.data;
        end
        return r;
    endfunction

    assign dp_we = dispatch.en && !clr;   // flush drops a same-cycle dispatch
    assign full  = &occupied;

    // lowest index wins, committed stores ahead of loads
    always_comb begin
        st_hit = 1'b0;
        ld_hit = 1'b0;
        st_idx = '0;
        ld_idx = '0;
        for (int i = slb_entries - 1; i >= 1; i--) begin
            if (occupied[i] && is_store(op_q[i]) && committed[i]
                    && rs1_q[i].valid && rs2_q[i].valid) begin
                st_hit = 1'b1;
                st_idx = i[tag_w-1:0];
            end
            if (occupied[i] && !is_store(op_q[i]) && !issued[i] && rs1_q[i].valid) begin
                ld_hit = 1'b1;
                ld_idx = i[tag_w-1:0];
            end
        end
    end

    assign sel_hit = st_hit | ld_hit;
    assign sel_idx = st_hit ? st_idx : ld_idx;
    // own pending request counts as busy, controller sees it only next cycle
    assign issue   = sel_hit && !mem_busy && !mem_req.en;

    assign rsp_live = mem_rsp.en && occupied[mem_rsp.tag] && issued[mem_rsp.tag] && !clr;

    always_ff @(posedge clk) begin
        if (rst) begin
            occupied  <= '0;
            committed <= '0;
            issued    <= '0;
        end else begin
            if (clr) begin
                for (int i = 1; i < slb_entries; i++) begin
                    if (!committed[i] && !(commit_en && commit_tag == i[tag_w-1:0]))
                        occupied[i] <= 1'b0;
                end
            end
            if (commit_en)
                committed[commit_tag] <= 1'b1;
            if (issue) begin
                if (st_hit) begin
                    occupied[sel_idx]  <= 1'b0;   // store retires on issue
                    committed[sel_idx] <= 1'b0;
                end else begin
                    issued[sel_idx] <= 1'b1;
                end
            end
            if (rsp_live)
                occupied[mem_rsp.tag] <= 1'b0;
            if (dp_we) begin
                occupied[dispatch.tag]  <= 1'b1;
                committed[dispatch.tag] <= 1'b0;
                issued[dispatch.tag]    <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        for (int i = 1; i < slb_entries; i++) begin
            rs1_q[i] <= snoop(rs1_q[i], ex_cdb, self_cdb);
            rs2_q[i] <= snoop(rs2_q[i], ex_cdb, self_cdb);
        end
        if (dp_we) begin
            op_q[dispatch.tag]  <= dispatch.op;
            imm_q[dispatch.tag] <= dispatch.imm;
            // a broadcast in the dispatch cycle is caught here as well
            rs1_q[dispatch.tag] <= snoop(operand_t'{valid: dispatch.rs1_tag == '0,
                                                    tag:   dispatch.rs1_tag,
                                                    data:  dispatch.rs1_data},
                                         ex_cdb, self_cdb);
            rs2_q[dispatch.tag] <= snoop(operand_t'{valid: dispatch.rs2_tag == '0,
                                                    tag:   dispatch.rs2_tag,
                                                    data:  dispatch.rs2_data},
                                         ex_cdb, self_cdb);
        end
    end

    always_ff @(posedge clk) begin
        if (rst)
            mem_req.en <= 1'b0;
        else
            mem_req.en <= issue;
        if (issue) begin
            mem_req.is_store  <= st_hit;
            mem_req.signed_ld <= op_q[sel_idx] inside {op_lb, op_lh};
            mem_req.size      <= op_size(op_q[sel_idx]);
            mem_req.tag       <= sel_idx;
            mem_req.addr      <= rs1_q[sel_idx].data + imm_q[sel_idx];
            mem_req.wdata     <= rs2_q[sel_idx].data;
        end
    end

    // load result onto the lsu bus, one cycle behind the controller
    always_ff @(posedge clk) begin
        if (rst)
            lsu_cdb.en <= 1'b0;
        else
            lsu_cdb.en <= rsp_live;
        if (rsp_live) begin
            lsu_cdb.tag  <= mem_rsp.tag;
            lsu_cdb.data <= mem_rsp.data;
        end
    end

endmodule

/* lsu_top.sv */
`timescale 1ns/1ps

module lsu_top import lsu_pkg::*; (
    input  logic             clk,
    input  logic             rst,
    input  logic             clr,
    input  dispatch_t        dispatch,
    input  cdb_t             ex_cdb,
    input  logic             commit_en,
    input  logic [tag_w-1:0] commit_tag,
    output cdb_t             lsu_cdb,
    output logic             full
);

    mem_req_t          mem_req;
    logic              mem_busy;
    mem_rsp_t          mem_rsp;
    logic [ram_aw-1:0] ram_addr;
    logic [3:0]        ram_be;
    logic [xlen-1:0]   ram_wdata;
    logic              ram_we;
    logic [xlen-1:0]   ram_rdata;

    slb slb_inst (
        .clk        (clk),
        .rst        (rst),
        .clr        (clr),
        .dispatch   (dispatch),
        .ex_cdb     (ex_cdb),
        .self_cdb   (lsu_cdb),     // own results wake waiting entries
        .commit_en  (commit_en),
        .commit_tag (commit_tag),
        .mem_busy   (mem_busy),
        .mem_rsp    (mem_rsp),
        .mem_req    (mem_req),
        .lsu_cdb    (lsu_cdb),
        .full       (full)
    );

    lsu_mem_ctrl lsu_mem_ctrl_inst (
        .clk       (clk),
        .rst       (rst),
        .mem_req   (mem_req),
        .mem_busy  (mem_busy),
        .mem_rsp   (mem_rsp),
        .ram_addr  (ram_addr),
        .ram_be    (ram_be),
        .ram_wdata (ram_wdata),
        .ram_we    (ram_we),
        .ram_rdata (ram_rdata)
    );

    data_ram data_ram_inst (
        .clk   (clk),
        .addr  (ram_addr),
        .be    (ram_be),
        .wdata (ram_wdata),
        .we    (ram_we),
        .rdata (ram_rdata)
    );

endmodule

/* lsu_top_assert.sv */
`timescale 1ns/1ps

module lsu_top_assert import lsu_pkg::*; (
    input logic     clk,
    input logic     rst,
    input mem_req_t mem_req,
    input logic     mem_busy,
    input mem_rsp_t mem_rsp,
    input cdb_t     lsu_cdb,
    input logic     full
);

    // controller never sees a request while busy
    no_req_while_busy: assert property (@(posedge clk) disable iff (rst)
        mem_req.en |-> !mem_busy)
        else $error("mem_req.en while mem_busy");

    // flushed results are dropped, so only this direction holds
    cdb_after_rsp: assert property (@(posedge clk) disable iff (rst)
        lsu_cdb.en |-> $past(mem_rsp.en) && $past(mem_rsp.tag) == lsu_cdb.tag)
        else $error("lsu_cdb.en without a response one cycle before");

    outputs_low_after_rst: assert property (@(posedge clk)
        rst |=> !mem_req.en && !mem_rsp.en && !lsu_cdb.en && !mem_busy && !full)
        else $error("outputs not low after reset");

endmodule

bind lsu_top lsu_top_assert lsu_top_assert_inst (
    .clk      (clk),
    .rst      (rst),
    .mem_req  (mem_req),
    .mem_busy (mem_busy),
    .mem_rsp  (mem_rsp),
    .lsu_cdb  (lsu_cdb),
    .full     (full)
);

/* tb_lsu_top.sv */
`timescale 1ns/1ps

module tb_lsu_top import lsu_pkg::*; ();

    logic             clk;
    logic             rst;
    logic             clr;
    dispatch_t        dispatch;
    cdb_t             ex_cdb;
    logic             commit_en;
    logic [tag_w-1:0] commit_tag;
    cdb_t             lsu_cdb;
    logic             full;

    logic [7:0]  img [1024];           // byte image of the ram
    logic        exp_valid [16];
    logic [31:0] exp_data [16];
    mem_op_e     st_op [16];           // stores waiting for commit
    logic [31:0] st_addr [16];
    logic [31:0] st_data [16];
    logic [31:0] lfsr;
    int          errors;
    int          checks;
    int          tests;
    int          ops;
    int          cycles;
    int          err_mark;

    lsu_top lsu_top_inst (
        .clk        (clk),
        .rst        (rst),
        .clr        (clr),
        .dispatch   (dispatch),
        .ex_cdb     (ex_cdb),
        .commit_en  (commit_en),
        .commit_tag (commit_tag),
        .lsu_cdb    (lsu_cdb),
        .full       (full)
    );

    always #50 clk = ~clk;

    function logic [31:0] rand_bits(input int n);
        logic [31:0] r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h8020_0003) : (lfsr >> 1);
            r = {r[30:0], lfsr[0]};
        end
        return r;
    endfunction

    function automatic logic [31:0] load_model(mem_op_e op, logic [31:0] addr);
        int a;
        a = int'(addr[9:0]);
        case (op)
            op_lb:   return {{24{img[a][7]}}, img[a]};
            op_lbu:  return {24'h0, img[a]};
            op_lh:   return {{16{img[(a & ~1) + 1][7]}}, img[(a & ~1) + 1], img[a & ~1]};
            op_lhu:  return {16'h0, img[(a & ~1) + 1], img[a & ~1]};
            default: return {img[(a & ~3) + 3], img[(a & ~3) + 2],
                             img[(a & ~3) + 1], img[a & ~3]};
        endcase
    endfunction

    function automatic void apply_store(mem_op_e op, logic [31:0] addr, logic [31:0] d);
        int a;
        a = int'(addr[9:0]);
        if (op == op_sb) begin
            img[a] = d[7:0];
        end else if (op == op_sh) begin
            img[a & ~1]       = d[7:0];
            img[(a & ~1) + 1] = d[15:8];
        end else begin
            for (int b = 0; b < 4; b++)
                img[(a & ~3) + b] = d[8*b +: 8];
        end
    endfunction

    task automatic step();
        @(posedge clk);
        #1;
    endtask

    task automatic check_cdb(cdb_t got);
        checks++;
        if (!exp_valid[got.tag]) begin
            $display("unexpected broadcast on lsu_cdb for tag %0d at %0t", got.tag, $time);
            errors++;
        end else begin
            if (got.data !== exp_data[got.tag]) begin
                $display("FAIL %0t lsu_cdb.data tag %0d got %h exp %h",
                         $time, got.tag, got.data, exp_data[got.tag]);
                errors++;
            end
            exp_valid[got.tag] = 1'b0;   // a second broadcast is an error
        end
    endtask

    task automatic check_full(logic got, logic exp);
        checks++;
        if (got !== exp) begin
            $display("FAIL %0t full got %b exp %b", $time, got, exp);
            errors++;
        end
    endtask

    task automatic send(mem_op_e op, int tag, int t1, logic [31:0] base, logic [31:0] imm,
                        int t2, logic [31:0] d);
        dispatch.en       = 1'b1;
        dispatch.op       = op;
        dispatch.tag      = 4'(tag);
        dispatch.imm      = imm;
        dispatch.rs1_tag  = 4'(t1);
        dispatch.rs1_data = t1 == 0 ? base : rand_bits(32);   // junk when pending
        dispatch.rs2_tag  = 4'(t2);
        dispatch.rs2_data = t2 == 0 ? d : rand_bits(32);
        ops++;
        step();
        dispatch.en = 1'b0;
    endtask

    // expected value fixed at dispatch from the base that rs1 will carry
    task automatic load(mem_op_e op, int tag, int t1, logic [31:0] base, logic [31:0] imm);
        exp_data[tag]  = load_model(op, base + imm);
        exp_valid[tag] = 1'b1;
        send(op, tag, t1, base, imm, 0, 0);
    endtask

    task automatic store(mem_op_e op, int tag, logic [31:0] addr, int t2, logic [31:0] d);
        logic [31:0] imm;
        imm = rand_bits(6);
        st_op[tag]   = op;
        st_addr[tag] = addr;
        st_data[tag] = d;
        send(op, tag, 0, addr - imm, imm, t2, d);
    endtask

    task automatic commit(int tag);
        apply_store(st_op[tag], st_addr[tag], st_data[tag]);
        commit_en  = 1'b1;
        commit_tag = 4'(tag);
        step();
        commit_en = 1'b0;
    endtask

    task automatic ex_send(int tag, logic [31:0] d);
        ex_cdb = '{en: 1'b1, tag: 4'(tag), data: d};
        step();
        ex_cdb.en = 1'b0;
    endtask

    task automatic drain();
        int idle;
        int n;
        idle = 0;
        n = 0;
        while (idle < 8 && n < 3000) begin
            step();
            n++;
            idle = (lsu_cdb.en || full) ? 0 : idle + 1;
        end
        if (idle < 8) begin
            $display("buffer did not drain at %0t", $time);
            errors++;
        end
        for (int t = 1; t < 16; t++) begin
            if (exp_valid[t]) begin
                $display("load tag %0d was never broadcast", t);
                errors++;
                exp_valid[t] = 1'b0;
            end
        end
    endtask

    task automatic end_test(string name);
        tests++;
        $display("test %0d %s: %0d errors", tests, name, errors - err_mark);
        err_mark = errors;
    endtask

    always @(negedge clk) begin
        if (!rst && lsu_cdb.en)
            check_cdb(lsu_cdb);
    end

    // limit grows with each dispatched operation
    always @(posedge clk) begin
        cycles++;
        if (cycles > 200 * ops + 2000) begin
            $display("watchdog expired after %0d cycles", cycles);
            $display("CHECKS FAILED");
            $finish;
        end
    end

    initial begin
        logic [31:0] v;
        logic [31:0] w;
        clk = 1'b0;
        rst = 1'b1;
        clr = 1'b0;
        dispatch = '0;
        ex_cdb = '0;
        commit_en = 1'b0;
        commit_tag = '0;
        lfsr = 32'd69;
        errors = 0;
        checks = 0;
        tests = 0;
        ops = 0;
        cycles = 0;
        err_mark = 0;
        for (int i = 0; i < 1024; i++)
            img[i] = 8'h00;
        for (int t = 0; t < 16; t++)
            exp_valid[t] = 1'b0;
        repeat (4) @(posedge clk);
        #1;
        rst = 1'b0;

        for (int t = 1; t < 16; t++) begin
            v = rand_bits(2);
            store(v == 0 ? op_sb : (v == 1 ? op_sh : op_sw), t, rand_bits(6) % 60, 0,
                  rand_bits(32));
            commit(t);
        end
        drain();
        for (int i = 0; i < 15; i++)
            load(op_lw, i + 1, 0, 32'(4 * i) - 32'd9, 32'd9);
        drain();
        end_test("store and word readback");

        for (int wd = 0; wd < 3; wd++) begin
            for (int off = 0; off < 4; off++) begin
                load(op_lb, 2 * off + 1, 0, 32'(4 * wd + off), 0);
                load(op_lbu, 2 * off + 2, 0, 32'(4 * wd + off), 0);
            end
            for (int h = 0; h < 2; h++) begin
                load(op_lh, 9 + 2 * h, 0, 32'(4 * wd + 2 * h) + 32'd5, -32'sd5);
                load(op_lhu, 10 + 2 * h, 0, 32'(4 * wd + 2 * h), 0);
            end
            drain();
        end
        end_test("sign and zero extension");

        v = 32'(4 * (rand_bits(4) % 15));
        w = load_model(op_lw, v);
        load(op_lw, 1, 15, v, 0);            // base arrives later on ex_cdb
        store(op_sw, 2, 800, 14, rand_bits(32));
        load(op_lw, 3, 1, w, 32'd12);        // base is load 1's result
        repeat (3) step();
        ex_send(15, v);
        ex_send(14, st_data[2]);
        drain();
        commit(2);
        drain();
        load(op_lw, 4, 0, 32'd800, 0);
        drain();
        end_test("dependent operands");

        store(op_sw, 1, 700, 0, rand_bits(32));
        repeat (10) step();
        load(op_lw, 2, 0, 32'd700, 0);       // store still uncommitted so old value
        drain();
        commit(1);
        drain();
        load(op_lw, 3, 0, 32'd700, 0);
        drain();
        end_test("commit gating");

        store(op_sw, 15, 900, 0, rand_bits(32));
        v = 32'(4 * (rand_bits(4) % 14));
        for (int t = 1; t < 15; t++)
            load(t % 2 ? op_lbu : op_lh, t, 15, v, rand_bits(3));
        step();
        check_full(full, 1'b1);
        commit(15);
        for (int n = 0; n < 50 && full; n++)
            step();
        check_full(full, 1'b0);
        ex_send(15, v);
        drain();
        end_test("capacity");

        store(op_sh, 6, 612, 14, rand_bits(32));
        commit(6);
        for (int t = 1; t < 6; t++)
            load(op_lw, t, 15, 32'd16, 32'(4 * t));
        repeat (2) step();
        clr = 1'b1;
        for (int t = 1; t < 6; t++)
            exp_valid[t] = 1'b0;
        step();
        clr = 1'b0;
        ex_send(15, 32'd16);
        ex_send(14, st_data[6]);
        drain();
        load(op_lhu, 7, 0, 32'd612, 0);
        drain();
        end_test("flush");

        $display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
        if (errors == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule

/* lsu_top.f */
lsu_pkg.sv
data_ram.sv
lsu_mem_ctrl.sv
slb.sv
lsu_top.sv
lsu_top_assert.sv
tb_lsu_top.sv

/* Makefile */
VERILATOR = verilator
FLAGS     = --binary --timing --assert -j 0
TOP       = tb_lsu_top
FILELIST  = lsu_top.f
PASS_MSG  = ALL CHECKS PASSED

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove build output"

test:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST)
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf obj_dir
